//--- vlog.f
logic/decodePkg.sv
logic/fieldIf.sv
logic/opIf.sv
logic/fieldExtract.sv
logic/operandGen.sv
logic/opFinalize.sv
logic/decodePipe.sv
sim/decodePipeTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= decodePipeTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?=

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/decodePipeTb.sv
//////////////////////////////
// Testbench for the RV32I decode pipe
// Stimulus table, random bubbles
// Expected queue and output checker
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decodePipeTb;
    import decodePkg::*;

    localparam int DRAIN_LIMIT = 50;

    typedef struct {
        InsnWord insn;
        logic badPC;
        OpKind kind;
        RegNum dst;
        RegNum srcA;
        RegNum srcB;
        OperandType typeA;
        OperandType typeB;
        ImmValue imm;
        AluCode alu;
        CondCode cond;
        MemAccessMode mem;
        // writeReg, writePC, isRelBranch, isCall, isReturn
        logic [4:0] flags;
    } Entry;

    logic clk = 1'b0;
    logic rstN;
    logic insnValid;
    InsnWord insn;
    logic illegalPC;
    logic opValid;
    OpKind opKind;
    RegNum dstReg;
    RegNum srcRegA;
    RegNum srcRegB;
    OperandType opTypeA;
    OperandType opTypeB;
    ImmValue imm;
    AluCode aluCode;
    CondCode cond;
    MemAccessMode memMode;
    logic writeReg;
    logic writePC;
    logic isRelBranch;
    logic isCall;
    logic isReturn;

    Entry entries[$];
    Entry expected[$];
    int valueErrors = 0;
    int strayErrors = 0;
    int flowErrors = 0;
    int outCount = 0;

    decodePipe dut (.*);

    always #10 clk = ~clk;

    task automatic addOp(input InsnWord word, input OpKind kind, input int dst, input int a,
                         input int b, input OperandType tA, input OperandType tB,
                         input int immVal, input AluCode alu, input CondCode cc,
                         input int mem, input logic [4:0] flags);
        Entry e;
        e.insn = word;
        e.badPC = 1'b0;
        e.kind = kind;
        e.dst = RegNum'(dst);
        e.srcA = RegNum'(a);
        e.srcB = RegNum'(b);
        e.typeA = tA;
        e.typeB = tB;
        e.imm = ImmValue'(immVal);
        e.alu = alu;
        e.cond = cc;
        e.mem = MemAccessMode'(mem);
        e.flags = flags;
        entries.push_back(e);
    endtask

    // Undefined word or bad fetch address clears all but the kind
    task automatic addBad(input InsnWord word, input logic badPC);
        addOp(word, badPC ? KIND_VIOLATION : KIND_ILLEGAL, 0, 0, 0, OPR_IMM, OPR_IMM, 0,
              ADD, AL, 0, 5'b00000);
        entries[entries.size() - 1].badPC = badPC;
    endtask

    task automatic checkField(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (exp == act) else begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic compareOp(input Entry e);
        checkField("opKind", 32'(e.kind), 32'(opKind));
        checkField("dstReg", 32'(e.dst), 32'(dstReg));
        checkField("srcRegA", 32'(e.srcA), 32'(srcRegA));
        checkField("srcRegB", 32'(e.srcB), 32'(srcRegB));
        checkField("opTypeA", 32'(e.typeA), 32'(opTypeA));
        checkField("opTypeB", 32'(e.typeB), 32'(opTypeB));
        checkField("imm", e.imm, imm);
        checkField("aluCode", 32'(e.alu), 32'(aluCode));
        checkField("cond", 32'(e.cond), 32'(cond));
        checkField("memMode", 32'(e.mem), 32'(memMode));
        checkField("writeReg", 32'(e.flags[4]), 32'(writeReg));
        checkField("writePC", 32'(e.flags[3]), 32'(writePC));
        checkField("isRelBranch", 32'(e.flags[2]), 32'(isRelBranch));
        checkField("isCall", 32'(e.flags[1]), 32'(isCall));
        checkField("isReturn", 32'(e.flags[0]), 32'(isReturn));
    endtask

    // Sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (opValid) begin
            outCount++;
            assert (expected.size() != 0) else begin
                $display("Output valid at %0t with no instruction pending", $time);
                strayErrors++;
            end
            if (expected.size() != 0) begin
                compareOp(expected.pop_front());
            end
        end
    end

    initial begin
        int idx;
        int waitCycles;
        int unsigned seedDummy;
        rstN = 1'b0;
        insnValid = 1'b0;
        insn = '0;
        illegalPC = 1'b0;
        seedDummy = $urandom(32'hedc6);

        // Integer and shift ops
        addOp(32'h002081B3, KIND_ALU, 3, 1, 2, OPR_REG, OPR_REG, 0, ADD, AL, 0, 5'b10000);
        addOp(32'h407302B3, KIND_ALU, 5, 6, 7, OPR_REG, OPR_REG, 0, SUB, AL, 0, 5'b10000);
        addOp(32'h0020A033, KIND_ALU, 0, 1, 2, OPR_REG, OPR_REG, 0, SLT, AL, 0, 5'b00000);
        addOp(32'h00C5C533, KIND_ALU, 10, 11, 12, OPR_REG, OPR_REG, 0, XOR, AL, 0, 5'b10000);
        addOp(32'h00921233, KIND_SHIFT, 4, 4, 9, OPR_REG, OPR_REG, 0, SLL, AL, 0, 5'b10000);
        addOp(32'h4074D413, KIND_SHIFT, 8, 9, 0, OPR_REG, OPR_IMM, 7, SRA, AL, 0, 5'b10000);
        addOp(32'hFF010113, KIND_ALU, 2, 2, 0, OPR_REG, OPR_IMM, -16, ADD, AL, 0, 5'b10000);
        // Upper immediates and direct jumps
        addOp(32'h123452B7, KIND_ALU, 5, 0, 0, OPR_REG, OPR_IMM, 32'h12345000, ADD, AL, 0,
              5'b10000);
        addOp(32'hFFFFF317, KIND_ALU, 6, 0, 0, OPR_PC, OPR_IMM, -4096, ADD, AL, 0, 5'b10000);
        addOp(32'h001000EF, KIND_BR, 1, 0, 0, OPR_PC, OPR_IMM, 2048, ADD, AL, 0, 5'b11110);
        addOp(32'hFFDFF06F, KIND_BR, 0, 0, 0, OPR_PC, OPR_IMM, -4, ADD, AL, 0, 5'b01100);
        addOp(32'h010002EF, KIND_BR, 5, 0, 0, OPR_PC, OPR_IMM, 16, ADD, AL, 0, 5'b11100);
        // Indirect jumps and branches
        addOp(32'h00008067, KIND_RIJ, 0, 1, 0, OPR_REG, OPR_IMM, 0, ADD, AL, 0, 5'b01001);
        addOp(32'h008280E7, KIND_RIJ, 1, 5, 0, OPR_REG, OPR_IMM, 8, ADD, AL, 0, 5'b11010);
        addOp(32'hFE208CE3, KIND_BR, 0, 1, 2, OPR_REG, OPR_REG, -8, ADD, EQ, 0, 5'b01100);
        addOp(32'h02039063, KIND_BR, 0, 7, 0, OPR_REG, OPR_REG, 32, ADD, NE, 0, 5'b01100);
        addOp(32'h00944163, KIND_BR, 0, 8, 9, OPR_REG, OPR_REG, 2, ADD, LT, 0, 5'b01100);
        addOp(32'h0062D263, KIND_BR, 0, 5, 6, OPR_REG, OPR_REG, 4, ADD, GE, 0, 5'b01100);
        addOp(32'h0041E863, KIND_BR, 0, 3, 4, OPR_REG, OPR_REG, 16, ADD, LTU, 0, 5'b01100);
        addOp(32'h00B570E3, KIND_BR, 0, 10, 11, OPR_REG, OPR_REG, 2048, ADD, GEU, 0, 5'b01100);
        // Loads and stores with memMode as {size, signed}
        addOp(32'hFFF30283, KIND_LOAD, 5, 6, 0, OPR_REG, OPR_IMM, -1, ADD, AL, 1, 5'b10000);
        addOp(32'h00645383, KIND_LOAD, 7, 8, 0, OPR_REG, OPR_IMM, 6, ADD, AL, 2, 5'b10000);
        addOp(32'h00054483, KIND_LOAD, 9, 10, 0, OPR_REG, OPR_IMM, 0, ADD, AL, 0, 5'b10000);
        addOp(32'h7FF12583, KIND_LOAD, 11, 2, 0, OPR_REG, OPR_IMM, 2047, ADD, AL, 5, 5'b10000);
        addOp(32'hFE512E23, KIND_STORE, 0, 2, 5, OPR_REG, OPR_REG, -4, ADD, AL, 5, 5'b00000);
        addOp(32'h003202A3, KIND_STORE, 0, 4, 3, OPR_REG, OPR_REG, 5, ADD, AL, 1, 5'b00000);
        addOp(32'h02639023, KIND_STORE, 0, 7, 6, OPR_REG, OPR_REG, 32, ADD, AL, 3, 5'b00000);
        // Fence opcode, mul, ld, branch funct3 2 and 3, then bad fetch addresses
        addBad(32'h0000000F, 1'b0);
        addBad(32'h022081B3, 1'b0);
        addBad(32'h00033283, 1'b0);
        addBad(32'h0020A063, 1'b0);
        addBad(32'h0020B063, 1'b0);
        addBad(32'h002081B3, 1'b1);
        addBad(32'h022081B3, 1'b1);

        repeat (10) @(posedge clk);
        #2 rstN = 1'b1;

        // One entry or one bubble per cycle
        idx = 0;
        while (idx < entries.size()) begin
            @(posedge clk);
            #2;
            if ($urandom_range(0, 3) == 0) begin
                insnValid = 1'b0;
            end else begin
                insnValid = 1'b1;
                insn = entries[idx].insn;
                illegalPC = entries[idx].badPC;
                expected.push_back(entries[idx]);
                idx++;
            end
        end
        @(posedge clk);
        #2;
        insnValid = 1'b0;
        insn = '0;
        illegalPC = 1'b0;

        waitCycles = 0;
        while (expected.size() != 0 && waitCycles < DRAIN_LIMIT) begin
            @(posedge clk);
            waitCycles++;
        end
        assert (expected.size() == 0) else begin
            $display("Timeout: %0d operations never left the pipe", expected.size());
            flowErrors++;
        end
        // A few quiet cycles to catch stray outputs
        repeat (4) @(posedge clk);
        assert (outCount == entries.size()) else begin
            $display("Got %0d operations for %0d instructions", outCount, entries.size());
            flowErrors++;
        end

        $display("Errors: %0d value, %0d stray output, %0d flow", valueErrors, strayErrors,
                 flowErrors);
        if (valueErrors == 0 && strayErrors == 0 && flowErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/decodePipe.sv
//////////////////////////////
// Three-stage RV32I decode pipe
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decodePipe (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     insnValid,
    input  decodePkg::InsnWord       insn,
    input  logic                     illegalPC,
    output logic                     opValid,
    output decodePkg::OpKind         opKind,
    output decodePkg::RegNum         dstReg,
    output decodePkg::RegNum         srcRegA,
    output decodePkg::RegNum         srcRegB,
    output decodePkg::OperandType    opTypeA,
    output decodePkg::OperandType    opTypeB,
    output decodePkg::ImmValue       imm,
    output decodePkg::AluCode        aluCode,
    output decodePkg::CondCode       cond,
    output decodePkg::MemAccessMode  memMode,
    output logic                     writeReg,
    output logic                     writePC,
    output logic                     isRelBranch,
    output logic                     isCall,
    output logic                     isReturn
);

    fieldIf fieldBus ();
    opIf opBus ();

    fieldExtract uFieldExtract (
        .clk       (clk),
        .rstN      (rstN),
        .insnValid (insnValid),
        .insn      (insn),
        .illegalPC (illegalPC),
        .fieldOut  (fieldBus)
    );

    operandGen uOperandGen (
        .clk     (clk),
        .rstN    (rstN),
        .fieldIn (fieldBus),
        .opOut   (opBus)
    );

    opFinalize uOpFinalize (
        .clk         (clk),
        .rstN        (rstN),
        .opIn        (opBus),
        .opValid     (opValid),
        .opKind      (opKind),
        .dstReg      (dstReg),
        .srcRegA     (srcRegA),
        .srcRegB     (srcRegB),
        .opTypeA     (opTypeA),
        .opTypeB     (opTypeB),
        .imm         (imm),
        .aluCode     (aluCode),
        .cond        (cond),
        .memMode     (memMode),
        .writeReg    (writeReg),
        .writePC     (writePC),
        .isRelBranch (isRelBranch),
        .isCall      (isCall),
        .isReturn    (isReturn)
    );

endmodule

`default_nettype wire

//--- logic/opFinalize.sv
//////////////////////////////
// Decode stage 3
// Write and control-flow flags
// Illegal and violation substitution
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opFinalize (
    input  logic                     clk,
    input  logic                     rstN,
    opIf.receiver                    opIn,
    output logic                     opValid,
    output decodePkg::OpKind         opKind,
    output decodePkg::RegNum         dstReg,
    output decodePkg::RegNum         srcRegA,
    output decodePkg::RegNum         srcRegB,
    output decodePkg::OperandType    opTypeA,
    output decodePkg::OperandType    opTypeB,
    output decodePkg::ImmValue       imm,
    output decodePkg::AluCode        aluCode,
    output decodePkg::CondCode       cond,
    output decodePkg::MemAccessMode  memMode,
    output logic                     writeReg,
    output logic                     writePC,
    output logic                     isRelBranch,
    output logic                     isCall,
    output logic                     isReturn
);
    import decodePkg::*;

    logic isBr;
    logic isRij;
    logic wrReg;
    logic bad;

    assign isBr = (opIn.opKind == KIND_BR);
    assign isRij = (opIn.opKind == KIND_RIJ);
    assign bad = opIn.undefined || opIn.illegalPC;

    // Branches carry dstReg zero, so only JAL writes among BR ops
    assign wrReg = (opIn.opKind inside {KIND_ALU, KIND_SHIFT, KIND_BR, KIND_RIJ, KIND_LOAD})
                   && (opIn.dstReg != ZERO_REGISTER);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            opValid     <= 1'b0;
            opKind      <= KIND_ALU;
            dstReg      <= '0;
            srcRegA     <= '0;
            srcRegB     <= '0;
            opTypeA     <= OPR_REG;
            opTypeB     <= OPR_REG;
            imm         <= '0;
            aluCode     <= ADD;
            cond        <= EQ;
            memMode     <= '0;
            writeReg    <= 1'b0;
            writePC     <= 1'b0;
            isRelBranch <= 1'b0;
            isCall      <= 1'b0;
            isReturn    <= 1'b0;
        end else begin
            opValid     <= opIn.valid;
            opKind      <= bad ? (opIn.illegalPC ? KIND_VIOLATION : KIND_ILLEGAL) : opIn.opKind;
            dstReg      <= bad ? ZERO_REGISTER : opIn.dstReg;
            srcRegA     <= bad ? ZERO_REGISTER : opIn.srcRegA;
            srcRegB     <= bad ? ZERO_REGISTER : opIn.srcRegB;
            opTypeA     <= bad ? OPR_IMM : opIn.opTypeA;
            opTypeB     <= bad ? OPR_IMM : opIn.opTypeB;
            imm         <= bad ? '0 : opIn.imm;
            aluCode     <= bad ? ADD : opIn.aluCode;
            cond        <= bad ? AL : opIn.cond;
            memMode     <= bad ? '0 : opIn.memMode;
            writeReg    <= !bad && wrReg;
            writePC     <= !bad && (isBr || isRij);
            isRelBranch <= !bad && isBr;
            isCall      <= !bad && wrReg && (isBr || isRij) && (opIn.dstReg == LINK_REGISTER);
            // Return is jalr x0 through the link register
            isReturn    <= !bad && isRij && (opIn.srcRegA == LINK_REGISTER)
                           && (opIn.dstReg == ZERO_REGISTER);
        end
    end

endmodule

`default_nettype wire

//--- logic/operandGen.sv
//////////////////////////////
// Decode stage 2
// Immediate, ALU code, condition, access mode
// Operand sources and register numbers
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operandGen (
    input  logic     clk,
    input  logic     rstN,
    fieldIf.receiver fieldIn,
    opIf.sender      opOut
);
    import decodePkg::*;

    logic [24:0] ib;
    logic [2:0] f3;
    logic isShift;
    ImmValue immI;
    ImmValue immS;
    ImmValue immB;
    ImmValue immU;
    ImmValue immJ;
    ImmValue immShamt;

    OpKind kind;
    RegNum dst;
    RegNum srcA;
    RegNum srcB;
    OperandType typeA;
    OperandType typeB;
    ImmValue imm;
    AluCode alu;
    CondCode cond;
    MemAccessMode memMode;

    assign ib = fieldIn.immBits;
    assign f3 = fieldIn.funct3;
    assign isShift = (f3 == F3_SLL) || (f3 == F3_SRL_SRA);

    // immBits[k] holds instruction bit k+7
    assign immI = {{20{ib[24]}}, ib[24:13]};
    assign immS = {{20{ib[24]}}, ib[24:18], ib[4:0]};
    assign immB = {{19{ib[24]}}, ib[24], ib[0], ib[23:18], ib[4:1], 1'b0};
    assign immU = {ib[24:5], 12'b0};
    assign immJ = {{11{ib[24]}}, ib[24], ib[12:5], ib[13], ib[23:14], 1'b0};
    assign immShamt = {27'b0, ib[17:13]};

    // ALU code from funct3, SUB only for the register form
    always_comb begin
        case (f3)
            3'd0: alu = (fieldIn.opClass == CLS_ALU_REG && fieldIn.altFunct) ? SUB : ADD;
            3'd1: alu = SLL;
            3'd2: alu = SLT;
            3'd3: alu = SLTU;
            3'd4: alu = XOR;
            3'd5: alu = fieldIn.altFunct ? SRA : SRL;
            3'd6: alu = OR;
            default: alu = AND;
        endcase
        if (!(fieldIn.opClass inside {CLS_ALU_REG, CLS_ALU_IMM})) begin
            alu = ADD;
        end
    end

    always_comb begin
        kind = KIND_ALU;
        dst = fieldIn.rd;
        srcA = fieldIn.rs1;
        srcB = '0;
        typeA = OPR_REG;
        typeB = OPR_IMM;
        imm = immI;
        cond = AL;
        memMode = '0;
        case (fieldIn.opClass)
            CLS_ALU_REG: begin
                kind = isShift ? KIND_SHIFT : KIND_ALU;
                srcB = fieldIn.rs2;
                typeB = OPR_REG;
                imm = '0;
            end
            CLS_ALU_IMM: begin
                kind = isShift ? KIND_SHIFT : KIND_ALU;
                imm = isShift ? immShamt : immI;
            end
            // LUI adds to register 0
            CLS_LUI: begin
                srcA = ZERO_REGISTER;
                imm = immU;
            end
            CLS_AUIPC: begin
                srcA = '0;
                typeA = OPR_PC;
                imm = immU;
            end
            CLS_JAL: begin
                kind = KIND_BR;
                srcA = '0;
                typeA = OPR_PC;
                imm = immJ;
            end
            CLS_JALR: kind = KIND_RIJ;
            CLS_BRANCH: begin
                kind = KIND_BR;
                dst = '0;
                srcB = fieldIn.rs2;
                typeB = OPR_REG;
                imm = immB;
                case (f3)
                    3'd0: cond = EQ;
                    3'd1: cond = NE;
                    3'd4: cond = LT;
                    3'd5: cond = GE;
                    3'd6: cond = LTU;
                    3'd7: cond = GEU;
                    default: cond = AL;
                endcase
            end
            CLS_LOAD, CLS_STORE: begin
                // Stores share the load size and sign decode
                memMode.size = MemSize'(f3[1:0]);
                memMode.isSigned = ~f3[2];
                if (fieldIn.opClass == CLS_STORE) begin
                    kind = KIND_STORE;
                    dst = '0;
                    srcB = fieldIn.rs2;
                    typeB = OPR_REG;
                    imm = immS;
                end else begin
                    kind = KIND_LOAD;
                end
            end
            default: begin
                kind = KIND_ILLEGAL;
                dst = '0;
                srcA = '0;
                typeA = OPR_IMM;
                imm = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            opOut.valid     <= 1'b0;
            opOut.opKind    <= KIND_ALU;
            opOut.dstReg    <= '0;
            opOut.srcRegA   <= '0;
            opOut.srcRegB   <= '0;
            opOut.opTypeA   <= OPR_REG;
            opOut.opTypeB   <= OPR_REG;
            opOut.imm       <= '0;
            opOut.aluCode   <= ADD;
            opOut.cond      <= EQ;
            opOut.memMode   <= '0;
            opOut.undefined <= 1'b0;
            opOut.illegalPC <= 1'b0;
        end else begin
            opOut.valid     <= fieldIn.valid;
            opOut.opKind    <= kind;
            opOut.dstReg    <= dst;
            opOut.srcRegA   <= srcA;
            opOut.srcRegB   <= srcB;
            opOut.opTypeA   <= typeA;
            opOut.opTypeB   <= typeB;
            opOut.imm       <= imm;
            opOut.aluCode   <= alu;
            opOut.cond      <= cond;
            opOut.memMode   <= memMode;
            opOut.undefined <= fieldIn.undefined;
            opOut.illegalPC <= fieldIn.illegalPC;
        end
    end

endmodule

`default_nettype wire

//--- logic/fieldExtract.sv
//////////////////////////////
// Decode stage 1
// Opcode class, field split, undefined check
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fieldExtract (
    input  logic               clk,
    input  logic               rstN,
    input  logic               insnValid,
    input  decodePkg::InsnWord insn,
    input  logic               illegalPC,
    fieldIf.sender             fieldOut
);
    import decodePkg::*;

    OpClass opClass;
    logic undefined;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign funct7 = insn[31:25];
    assign funct3 = insn[14:12];

    always_comb begin
        opClass = CLS_UNDEF;
        undefined = 1'b0;
        case (OpCode'(insn[6:0]))
            OP: begin
                opClass = CLS_ALU_REG;
                // Bit 30 alone only on ADD/SUB and SRL/SRA, M-extension falls out here
                if (funct7 == FUNCT7_ALT) begin
                    undefined = (funct3 != F3_ADD_SUB) && (funct3 != F3_SRL_SRA);
                end else begin
                    undefined = (funct7 != FUNCT7_ZERO);
                end
            end
            OP_IMM: begin
                opClass = CLS_ALU_IMM;
                if (funct3 == F3_SLL) begin
                    undefined = (funct7 != FUNCT7_ZERO);
                end else if (funct3 == F3_SRL_SRA) begin
                    undefined = (funct7 != FUNCT7_ZERO) && (funct7 != FUNCT7_ALT);
                end
            end
            LUI:    opClass = CLS_LUI;
            AUIPC:  opClass = CLS_AUIPC;
            JAL:    opClass = CLS_JAL;
            JALR:   opClass = CLS_JALR;
            BRANCH: begin
                opClass = CLS_BRANCH;
                undefined = (funct3 == 3'd2) || (funct3 == 3'd3);
            end
            LOAD: begin
                opClass = CLS_LOAD;
                undefined = funct3 inside {3'd3, 3'd6, 3'd7};
            end
            STORE: begin
                opClass = CLS_STORE;
                undefined = (funct3 > 3'd2);
            end
            default: undefined = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fieldOut.valid     <= 1'b0;
            fieldOut.opClass   <= CLS_ALU_REG;
            fieldOut.rd        <= '0;
            fieldOut.rs1       <= '0;
            fieldOut.rs2       <= '0;
            fieldOut.funct3    <= '0;
            fieldOut.altFunct  <= 1'b0;
            fieldOut.immBits   <= '0;
            fieldOut.undefined <= 1'b0;
            fieldOut.illegalPC <= 1'b0;
        end else begin
            fieldOut.valid     <= insnValid;
            fieldOut.opClass   <= opClass;
            fieldOut.rd        <= insn[11:7];
            fieldOut.rs1       <= insn[19:15];
            fieldOut.rs2       <= insn[24:20];
            fieldOut.funct3    <= funct3;
            fieldOut.altFunct  <= insn[30];
            fieldOut.immBits   <= insn[31:7];
            fieldOut.undefined <= undefined;
            fieldOut.illegalPC <= illegalPC;
        end
    end

endmodule

`default_nettype wire

//--- logic/opIf.sv
//////////////////////////////
// Built operation
// Stage 2 to stage 3 link
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface opIf;
    import decodePkg::*;

    logic valid;
    OpKind opKind;
    RegNum dstReg;
    RegNum srcRegA;
    RegNum srcRegB;
    OperandType opTypeA;
    OperandType opTypeB;
    ImmValue imm;
    AluCode aluCode;
    CondCode cond;
    MemAccessMode memMode;
    logic undefined;
    logic illegalPC;

    modport sender(output valid, opKind, dstReg, srcRegA, srcRegB, opTypeA, opTypeB,
                   imm, aluCode, cond, memMode, undefined, illegalPC);
    modport receiver(input valid, opKind, dstReg, srcRegA, srcRegB, opTypeA, opTypeB,
                     imm, aluCode, cond, memMode, undefined, illegalPC);
endinterface

`default_nettype wire

//--- logic/fieldIf.sv
//////////////////////////////
// Extracted instruction fields
// Stage 1 to stage 2 link
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface fieldIf;
    import decodePkg::*;

    logic valid;
    OpClass opClass;
    RegNum rd;
    RegNum rs1;
    RegNum rs2;
    logic [2:0] funct3;
    // Instruction bit 30
    logic altFunct;
    // Instruction bits 31 down to 7
    logic [24:0] immBits;
    logic undefined;
    logic illegalPC;

    modport sender(output valid, opClass, rd, rs1, rs2, funct3, altFunct,
                   immBits, undefined, illegalPC);
    modport receiver(input valid, opClass, rd, rs1, rs2, funct3, altFunct,
                     immBits, undefined, illegalPC);
endinterface

`default_nettype wire

//--- logic/decodePkg.sv
//////////////////////////////
// RV32I decode pipe shared types
// Instruction fields, opcodes, op classes and kinds
// ALU, condition and memory access encodings
//////////////////////////////
`default_nettype none

package decodePkg;

    typedef logic [31:0] InsnWord;
    typedef logic [4:0] RegNum;
    typedef logic [31:0] ImmValue;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        AUIPC  = 7'b0010111,
        LUI    = 7'b0110111
    } OpCode;

    typedef enum logic [3:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_UNDEF
    } OpClass;

    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_SHIFT,
        KIND_BR,
        KIND_RIJ,
        KIND_LOAD,
        KIND_STORE,
        KIND_ILLEGAL,
        KIND_VIOLATION
    } OpKind;

    // Shift direction is part of the ALU code
    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA
    } AluCode;

    // AL is the unconditional case
    typedef enum logic [2:0] {
        EQ, NE, LT, GE, LTU, GEU, AL
    } CondCode;

    typedef enum logic [1:0] {
        OPR_REG,
        OPR_IMM,
        OPR_PC
    } OperandType;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } MemSize;

    typedef struct packed {
        MemSize size;
        logic   isSigned;
    } MemAccessMode;

    localparam RegNum ZERO_REGISTER = 5'd0;
    localparam RegNum LINK_REGISTER = 5'd1;

    // funct7 and funct3 values used by the decode checks
    localparam logic [6:0] FUNCT7_ZERO = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;
    localparam logic [2:0] F3_ADD_SUB  = 3'd0;
    localparam logic [2:0] F3_SLL      = 3'd1;
    localparam logic [2:0] F3_SRL_SRA  = 3'd5;

endpackage

`default_nettype wire
